// File: common/dmmu_spr_pkg.sv
/*
 * Address map of the data MMU group on the special-purpose-register bus.
 * Field positions used to decode group, array kind, way and set.
 */

package dmmu_spr_pkg;

   // Bus address width
   localparam int SPR_ADDR_WIDTH = 16;

   // Group field in bits 15:11
   localparam int SPR_GROUP_LO = 11;
   localparam int SPR_GROUP_WIDTH = 5;
   localparam logic [SPR_GROUP_WIDTH-1:0] SPR_GROUP_DMMU = 5'd1;

   // Either of these bits set selects a TLB array
   localparam int SPR_TLB_SEL_LO = 9;
   localparam int SPR_TLB_SEL_HI = 10;

   // Set for translate, clear for match
   localparam int SPR_TRANS_BIT = 7;

   // Way index
   localparam int SPR_WAY_BIT = 8;

   // Array bases, set number goes in the low bits
   localparam logic [SPR_ADDR_WIDTH-1:0] DTLB_W0_MATCH_BASE = 16'h0A00;
   localparam logic [SPR_ADDR_WIDTH-1:0] DTLB_W0_TRANS_BASE = 16'h0A80;
   localparam logic [SPR_ADDR_WIDTH-1:0] DTLB_W1_MATCH_BASE = 16'h0B00;
   localparam logic [SPR_ADDR_WIDTH-1:0] DTLB_W1_TRANS_BASE = 16'h0B80;

endpackage

// File: common/dmmu_tlb_pkg.sv
/*
 * Data TLB geometry and page sizes, plus the register word shared by
 * the match and translate arrays with one view for each array.
 */

package dmmu_tlb_pkg;

   localparam int DATA_WIDTH = 32;

   // 8 KB pages
   localparam int PAGE_BITS = 13;
   // Offset width passed through on a miss
   localparam int HUGE_PAGE_BITS = 24;

   localparam int SET_WIDTH = 6;
   localparam int NUM_SETS = 64;
   localparam int NUM_WAYS = 2;
   localparam int WAY_WIDTH = 1;

   localparam int VPN_WIDTH = 19;
   localparam int PPN_WIDTH = 19;

   // Match register layout
   typedef struct packed {
      logic [VPN_WIDTH-1:0] vpn;
      logic [PAGE_BITS-2:0] unused;
      logic                 valid;
   } tlb_match_t;

   // Translate register layout
   typedef struct packed {
      logic [PPN_WIDTH-1:0] ppn;
      logic [2:0]           rsvd;
      logic                 swe;
      logic                 sre;
      logic                 uwe;
      logic                 ure;
      logic                 dirty;
      logic                 accessed;
      // Weakly ordered memory
      logic                 wom;
      // Write-back cache
      logic                 wbc;
      logic                 ci;
      logic                 cc;
   } tlb_trans_t;

   // One array word, read as match or translate depending on the array
   typedef union packed {
      tlb_match_t match_view;
      tlb_trans_t trans_view;
   } tlb_word_u;

endpackage

// File: hw/dmmu/dtlb_reg_array.sv
/*
 * Single-port array of TLB register words with a registered read.
 * Used once per way for the match registers and once for translate.
 */

`timescale 1ns/1ps

module dtlb_reg_array (
   input  logic                                clk,
   input  logic [dmmu_tlb_pkg::SET_WIDTH-1:0]  addr_i,
   input  logic                                we_i,
   input  dmmu_tlb_pkg::tlb_word_u             wdata_i,
   output dmmu_tlb_pkg::tlb_word_u             rdata_o
);

   import dmmu_tlb_pkg::*;

   tlb_word_u mem [NUM_SETS];

   // Read returns the word held before a same-cycle write
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[addr_i] <= wdata_i;
      end
      rdata_o <= mem[addr_i];
   end

endmodule

// File: hw/dmmu/dtlb_lookup.sv
/*
 * Combinational TLB compare on the words read one cycle earlier.
 * Produces the physical address, miss, cache-inhibit and page fault.
 */

`timescale 1ns/1ps

module dtlb_lookup (
   input  logic [dmmu_tlb_pkg::DATA_WIDTH-1:0]                  virt_addr_match_i,
   input  dmmu_tlb_pkg::tlb_word_u [dmmu_tlb_pkg::NUM_WAYS-1:0] match_rdata_i,
   input  dmmu_tlb_pkg::tlb_word_u [dmmu_tlb_pkg::NUM_WAYS-1:0] trans_rdata_i,
   input  logic                                                 op_load_i,
   input  logic                                                 op_store_i,
   input  logic                                                 supervisor_mode_i,
   output logic [dmmu_tlb_pkg::DATA_WIDTH-1:0]                  phys_addr_o,
   output logic                                                 cache_inhibit_o,
   output logic                                                 tlb_miss_o,
   output logic                                                 pagefault_o
);

   import dmmu_tlb_pkg::*;

   logic [NUM_WAYS-1:0] way_hit;
   logic                ure;
   logic                uwe;
   logic                sre;
   logic                swe;

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_hit
      assign way_hit[w] = match_rdata_i[w].match_view.valid &
                          (match_rdata_i[w].match_view.vpn ==
                           virt_addr_match_i[DATA_WIDTH-1:PAGE_BITS]);
   end

   always_comb begin
      // Miss defaults, no rights at all
      tlb_miss_o      = 1'b1;
      phys_addr_o     = {{(DATA_WIDTH-HUGE_PAGE_BITS){1'b0}},
                         virt_addr_match_i[HUGE_PAGE_BITS-1:0]};
      cache_inhibit_o = 1'b0;
      ure             = 1'b0;
      uwe             = 1'b0;
      sre             = 1'b0;
      swe             = 1'b0;

      for (int w = 0; w < NUM_WAYS; w++) begin
         if (way_hit[w]) begin
            tlb_miss_o      = 1'b0;
            phys_addr_o     = {trans_rdata_i[w].trans_view.ppn,
                               virt_addr_match_i[PAGE_BITS-1:0]};
            cache_inhibit_o = trans_rdata_i[w].trans_view.ci;
            ure             = trans_rdata_i[w].trans_view.ure;
            uwe             = trans_rdata_i[w].trans_view.uwe;
            sre             = trans_rdata_i[w].trans_view.sre;
            swe             = trans_rdata_i[w].trans_view.swe;
         end
      end
   end

   // A miss leaves every right clear, so any access on a miss faults
   assign pagefault_o = supervisor_mode_i ?
                        (op_store_i & ~swe) | (op_load_i & ~sre) :
                        (op_store_i & ~uwe) | (op_load_i & ~ure);

   // Software keeps the VPNs of one set distinct across ways
   always_comb begin
      if (!$isunknown(way_hit)) begin
         a_one_hit: assert ($onehot0(way_hit));
      end
      if (!$isunknown({tlb_miss_o, cache_inhibit_o})) begin
         a_miss_ci: assert (!(tlb_miss_o && cache_inhibit_o));
      end
   end

endmodule

// File: hw/dmmu/dmmu_spr_slave.sv
/*
 * SPR bus slave for the MMU group. Decodes the TLB arrays, drives the
 * array index and write enables, and returns read data with the ack
 * one cycle after the strobe.
 */

`timescale 1ns/1ps

module dmmu_spr_slave (
   input  logic                                         clk,
   input  logic                                         rst,

   input  logic [dmmu_spr_pkg::SPR_ADDR_WIDTH-1:0]      spr_bus_addr_i,
   input  logic                                         spr_bus_we_i,
   input  logic                                         spr_bus_stb_i,
   input  logic [dmmu_tlb_pkg::DATA_WIDTH-1:0]          spr_bus_dat_i,
   input  logic [dmmu_tlb_pkg::DATA_WIDTH-1:0]          virt_addr_i,

   // Read-back from the arrays
   input  dmmu_tlb_pkg::tlb_word_u [dmmu_tlb_pkg::NUM_WAYS-1:0] match_rdata_i,
   input  dmmu_tlb_pkg::tlb_word_u [dmmu_tlb_pkg::NUM_WAYS-1:0] trans_rdata_i,

   output logic [dmmu_tlb_pkg::SET_WIDTH-1:0]           arr_addr_o,
   output logic [dmmu_tlb_pkg::NUM_WAYS-1:0]            match_we_o,
   output logic [dmmu_tlb_pkg::NUM_WAYS-1:0]            trans_we_o,
   output dmmu_tlb_pkg::tlb_word_u                      arr_wdata_o,
   output logic [dmmu_tlb_pkg::DATA_WIDTH-1:0]          spr_bus_dat_o,
   output logic                                         spr_bus_ack_o
);

   import dmmu_tlb_pkg::*;
   import dmmu_spr_pkg::*;

   logic                 group_hit;
   logic                 tlb_sel;
   logic                 match_cs;
   logic                 trans_cs;
   logic [WAY_WIDTH-1:0] spr_way;

   logic                 ack_r;
   logic                 match_cs_r;
   logic                 trans_cs_r;
   logic [WAY_WIDTH-1:0] way_r;

   assign group_hit = spr_bus_addr_i[SPR_GROUP_LO +: SPR_GROUP_WIDTH] == SPR_GROUP_DMMU;

   // Only bits 10:9 tell a TLB array apart from other group registers
   assign tlb_sel = spr_bus_stb_i & group_hit &
                    (spr_bus_addr_i[SPR_TLB_SEL_LO] | spr_bus_addr_i[SPR_TLB_SEL_HI]);

   assign match_cs = tlb_sel & ~spr_bus_addr_i[SPR_TRANS_BIT];
   assign trans_cs = tlb_sel & spr_bus_addr_i[SPR_TRANS_BIT];
   assign spr_way  = spr_bus_addr_i[SPR_WAY_BIT +: WAY_WIDTH];

   // SPR takes the index away from the lookup while it owns an array
   assign arr_addr_o = tlb_sel ? spr_bus_addr_i[SET_WIDTH-1:0]
                               : virt_addr_i[PAGE_BITS +: SET_WIDTH];

   assign arr_wdata_o = spr_bus_dat_i;

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_we
      assign match_we_o[w] = match_cs & spr_bus_we_i & (spr_way == WAY_WIDTH'(w));
      assign trans_we_o[w] = trans_cs & spr_bus_we_i & (spr_way == WAY_WIDTH'(w));
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_r      <= 1'b0;
         match_cs_r <= 1'b0;
         trans_cs_r <= 1'b0;
      end else begin
         ack_r      <= spr_bus_stb_i & group_hit;
         match_cs_r <= match_cs;
         trans_cs_r <= trans_cs;
      end
   end

   // Way of the access picks the read-back word in the ack cycle
   always_ff @(posedge clk) begin
      way_r <= spr_way;
   end

   // Drops at once if the master releases the strobe
   assign spr_bus_ack_o = ack_r & spr_bus_stb_i & group_hit;

   // Non-TLB group registers read as zero
   always_comb begin
      spr_bus_dat_o = '0;
      if (match_cs_r) begin
         spr_bus_dat_o = match_rdata_i[way_r];
      end else if (trans_cs_r) begin
         spr_bus_dat_o = trans_rdata_i[way_r];
      end
   end

   // At most one array word across both ways is written in a cycle
   a_one_write: assert property (@(posedge clk) disable iff (rst)
      $onehot0({match_we_o, trans_we_o}));

   // Ack only after a full cycle of held strobe
   a_ack_stb: assert property (@(posedge clk) disable iff (rst)
      spr_bus_ack_o |-> spr_bus_stb_i && $past(spr_bus_stb_i));

endmodule

// File: hw/dmmu/dmmu_top.sv
/*
 * Data MMU top level with software-managed TLB.
 * Ties the SPR slave, two ways of match and translate arrays and the
 * lookup logic together.
 */

`timescale 1ns/1ps

module dmmu_top (
   input  logic                                      clk,
   input  logic                                      rst,

   // Lookup side
   input  logic [dmmu_tlb_pkg::DATA_WIDTH-1:0]       virt_addr_i,
   input  logic [dmmu_tlb_pkg::DATA_WIDTH-1:0]       virt_addr_match_i,
   input  logic                                      op_load_i,
   input  logic                                      op_store_i,
   input  logic                                      supervisor_mode_i,
   output logic [dmmu_tlb_pkg::DATA_WIDTH-1:0]       phys_addr_o,
   output logic                                      cache_inhibit_o,
   output logic                                      tlb_miss_o,
   output logic                                      pagefault_o,

   // SPR bus
   input  logic [dmmu_spr_pkg::SPR_ADDR_WIDTH-1:0]   spr_bus_addr_i,
   input  logic                                      spr_bus_we_i,
   input  logic                                      spr_bus_stb_i,
   input  logic [dmmu_tlb_pkg::DATA_WIDTH-1:0]       spr_bus_dat_i,
   output logic [dmmu_tlb_pkg::DATA_WIDTH-1:0]       spr_bus_dat_o,
   output logic                                      spr_bus_ack_o
);

   import dmmu_tlb_pkg::*;

   logic [SET_WIDTH-1:0]           arr_addr;
   logic [NUM_WAYS-1:0]            match_we;
   logic [NUM_WAYS-1:0]            trans_we;
   tlb_word_u                      arr_wdata;
   tlb_word_u [NUM_WAYS-1:0]       match_rdata;
   tlb_word_u [NUM_WAYS-1:0]       trans_rdata;

   dmmu_spr_slave u_spr (
      .clk            (clk),
      .rst            (rst),
      .spr_bus_addr_i (spr_bus_addr_i),
      .spr_bus_we_i   (spr_bus_we_i),
      .spr_bus_stb_i  (spr_bus_stb_i),
      .spr_bus_dat_i  (spr_bus_dat_i),
      .virt_addr_i    (virt_addr_i),
      .match_rdata_i  (match_rdata),
      .trans_rdata_i  (trans_rdata),
      .arr_addr_o     (arr_addr),
      .match_we_o     (match_we),
      .trans_we_o     (trans_we),
      .arr_wdata_o    (arr_wdata),
      .spr_bus_dat_o  (spr_bus_dat_o),
      .spr_bus_ack_o  (spr_bus_ack_o)
   );

   // All four arrays share one index and one write word
   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      dtlb_reg_array u_match (
         .clk     (clk),
         .addr_i  (arr_addr),
         .we_i    (match_we[w]),
         .wdata_i (arr_wdata),
         .rdata_o (match_rdata[w])
      );

      dtlb_reg_array u_trans (
         .clk     (clk),
         .addr_i  (arr_addr),
         .we_i    (trans_we[w]),
         .wdata_i (arr_wdata),
         .rdata_o (trans_rdata[w])
      );
   end

   dtlb_lookup u_lookup (
      .virt_addr_match_i (virt_addr_match_i),
      .match_rdata_i     (match_rdata),
      .trans_rdata_i     (trans_rdata),
      .op_load_i         (op_load_i),
      .op_store_i        (op_store_i),
      .supervisor_mode_i (supervisor_mode_i),
      .phys_addr_o       (phys_addr_o),
      .cache_inhibit_o   (cache_inhibit_o),
      .tlb_miss_o        (tlb_miss_o),
      .pagefault_o       (pagefault_o)
   );

endmodule

// File: dv/dmmu_clk_gen.sv
/*
 * Clock and reset source for the data MMU testbench.
 * 20 ns clock, reset held high over the first four rising edges.
 */

`timescale 1ns/1ps

module dmmu_clk_gen (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;
   end

   // Released on a falling edge, away from the sampling edge
   initial begin
      rst_o = 1'b1;
      repeat (4) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

// File: dv/dmmu_tb.sv
/*
 * Testbench for the data MMU. Keeps a model of the four TLB arrays,
 * drives SPR accesses and pipelined lookups on the falling edge and
 * checks the DUT with concurrent assertions against the model.
 */

`timescale 1ns/1ps

module dmmu_tb;

   import dmmu_tlb_pkg::*;
   import dmmu_spr_pkg::*;

   localparam int SEED = 50302;
   localparam int ACK_TIMEOUT = 16;
   localparam int RST_TIMEOUT = 20;

   logic        clk;
   logic        rst;
   logic [31:0] virt_addr_i;
   logic [31:0] virt_addr_match_i;
   logic        op_load_i;
   logic        op_store_i;
   logic        supervisor_mode_i;
   logic [31:0] phys_addr_o;
   logic        cache_inhibit_o;
   logic        tlb_miss_o;
   logic        pagefault_o;
   logic [15:0] spr_bus_addr_i;
   logic        spr_bus_we_i;
   logic        spr_bus_stb_i;
   logic [31:0] spr_bus_dat_i;
   logic [31:0] spr_bus_dat_o;
   logic        spr_bus_ack_o;

   // Model of match and translate words, per way and set
   logic [31:0] match_mdl [NUM_WAYS][NUM_SETS];
   logic [31:0] trans_mdl [NUM_WAYS][NUM_SETS];

   logic        chk_lookup;
   logic        chk_read;
   logic        exp_ack;
   logic [31:0] exp_phys;
   logic [31:0] exp_rdata;
   logic        exp_miss;
   logic        exp_ci;
   logic        exp_pf;

   // Lookup issued last cycle, compared in the current one
   logic        pend_valid;
   logic [31:0] pend_addr;
   logic        pend_ld;
   logic        pend_st;
   logic        pend_sup;

   dmmu_clk_gen u_clk (
      .clk_o (clk),
      .rst_o (rst)
   );

   dmmu_top u_dut (
      .clk               (clk),
      .rst               (rst),
      .virt_addr_i       (virt_addr_i),
      .virt_addr_match_i (virt_addr_match_i),
      .op_load_i         (op_load_i),
      .op_store_i        (op_store_i),
      .supervisor_mode_i (supervisor_mode_i),
      .phys_addr_o       (phys_addr_o),
      .cache_inhibit_o   (cache_inhibit_o),
      .tlb_miss_o        (tlb_miss_o),
      .pagefault_o       (pagefault_o),
      .spr_bus_addr_i    (spr_bus_addr_i),
      .spr_bus_we_i      (spr_bus_we_i),
      .spr_bus_stb_i     (spr_bus_stb_i),
      .spr_bus_dat_i     (spr_bus_dat_i),
      .spr_bus_dat_o     (spr_bus_dat_o),
      .spr_bus_ack_o     (spr_bus_ack_o)
   );

   task automatic stop_failed();
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic value_fail(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
      $display("Fail %s got 0x%08h expected 0x%08h", name, got, expected);
      stop_failed();
   endtask

   a_phys: assert property (@(posedge clk) disable iff (rst)
      chk_lookup |-> phys_addr_o == exp_phys)
      else value_fail("phys_addr_o", $sampled(phys_addr_o), $sampled(exp_phys));
   a_miss: assert property (@(posedge clk) disable iff (rst)
      chk_lookup |-> tlb_miss_o == exp_miss)
      else value_fail("tlb_miss_o", 32'($sampled(tlb_miss_o)), 32'($sampled(exp_miss)));
   a_ci: assert property (@(posedge clk) disable iff (rst)
      chk_lookup |-> cache_inhibit_o == exp_ci)
      else value_fail("cache_inhibit_o", 32'($sampled(cache_inhibit_o)),
                      32'($sampled(exp_ci)));
   a_pf: assert property (@(posedge clk) disable iff (rst)
      chk_lookup |-> pagefault_o == exp_pf)
      else value_fail("pagefault_o", 32'($sampled(pagefault_o)), 32'($sampled(exp_pf)));
   a_rdata: assert property (@(posedge clk) disable iff (rst)
      spr_bus_ack_o && chk_read |-> spr_bus_dat_o == exp_rdata)
      else value_fail("spr_bus_dat_o", $sampled(spr_bus_dat_o), $sampled(exp_rdata));
   // Ack exactly one cycle after the strobe rises, never on its own
   a_ack_early: assert property (@(posedge clk) disable iff (rst)
      $rose(spr_bus_stb_i) |-> !spr_bus_ack_o)
      else value_fail("spr_bus_ack_o", 32'd1, 32'd0);
   a_ack_next: assert property (@(posedge clk) disable iff (rst)
      $rose(spr_bus_stb_i) && exp_ack |=> spr_bus_ack_o)
      else value_fail("spr_bus_ack_o", 32'd0, 32'd1);
   a_ack_stb: assert property (@(posedge clk) disable iff (rst)
      spr_bus_ack_o |-> spr_bus_stb_i && exp_ack)
      else value_fail("spr_bus_ack_o", 32'd1, 32'd0);

   task automatic spr_access(input logic [15:0] addr, input logic we,
                             input logic [31:0] wdata, input logic group1,
                             input logic [31:0] rdata);
      int  n;
      logic done;
      n = 0;
      done = 1'b0;
      @(negedge clk);
      spr_bus_addr_i = addr;
      spr_bus_we_i = we;
      spr_bus_dat_i = wdata;
      exp_ack = group1;
      exp_rdata = rdata;
      chk_read = ~we;
      spr_bus_stb_i = 1'b1;
      while (!done) begin
         @(negedge clk);
         n++;
         if (spr_bus_ack_o) begin
            // Strobe stays up over the rising edge that closes the ack cycle
            @(negedge clk);
            done = 1'b1;
         end else if (n >= ACK_TIMEOUT) begin
            if (group1) begin
               $display("No ack from the SPR slave within %0d cycles", ACK_TIMEOUT);
               stop_failed();
            end else begin
               // Other groups are expected to stay silent
               done = 1'b1;
            end
         end
      end
      spr_bus_stb_i = 1'b0;
      spr_bus_we_i = 1'b0;
      chk_read = 1'b0;
   endtask

   function automatic logic [15:0] addr_of(input logic way, input logic trans,
                                           input logic [5:0] set);
      return DTLB_W0_MATCH_BASE | {7'd0, way, trans, 1'b0, set};
   endfunction

   task automatic tlb_write(input logic way, input logic trans, input logic [5:0] set,
                            input logic [31:0] data);
      spr_access(addr_of(way, trans, set), 1'b1, data, 1'b1, 32'h0);
      if (trans) begin
         trans_mdl[way][set] = data;
      end else begin
         match_mdl[way][set] = data;
      end
   endtask

   task automatic tlb_read(input logic way, input logic trans, input logic [5:0] set);
      spr_access(addr_of(way, trans, set), 1'b0, 32'h0, 1'b1,
                 trans ? trans_mdl[way][set] : match_mdl[way][set]);
   endtask

   // Valid match entry for the page of va, plus its translate word
   task automatic install(input logic way, input logic [31:0] va, input logic [31:0] tword);
      tlb_write(way, 1'b0, va[18:13], {va[31:13], 12'h000, 1'b1});
      tlb_write(way, 1'b1, va[18:13], tword);
   endtask

   task automatic predict(input logic [31:0] va, input logic ld, input logic st,
                          input logic sup);
      logic [31:0] mw;
      logic [31:0] tw;
      logic [3:0]  perm;
      exp_miss = 1'b1;
      exp_phys = {8'h00, va[23:0]};
      exp_ci = 1'b0;
      perm = 4'b0000;
      for (int w = 0; w < NUM_WAYS; w++) begin
         mw = match_mdl[w][va[18:13]];
         tw = trans_mdl[w][va[18:13]];
         if (mw[0] && mw[31:13] == va[31:13]) begin
            exp_miss = 1'b0;
            exp_phys = {tw[31:13], va[12:0]};
            exp_ci = tw[1];
            // SWE, SRE, UWE, URE
            perm = tw[9:6];
         end
      end
      exp_pf = sup ? (st & ~perm[3]) | (ld & ~perm[2]) : (st & ~perm[1]) | (ld & ~perm[0]);
   endtask

   task automatic present_pending();
      if (pend_valid) begin
         virt_addr_match_i = pend_addr;
         op_load_i = pend_ld;
         op_store_i = pend_st;
         supervisor_mode_i = pend_sup;
         predict(pend_addr, pend_ld, pend_st, pend_sup);
         chk_lookup = 1'b1;
      end else begin
         op_load_i = 1'b0;
         op_store_i = 1'b0;
         chk_lookup = 1'b0;
      end
   endtask

   task automatic lookup(input logic [31:0] va, input logic ld, input logic st,
                         input logic sup);
      @(negedge clk);
      present_pending();
      virt_addr_i = va;
      pend_valid = 1'b1;
      pend_addr = va;
      pend_ld = ld;
      pend_st = st;
      pend_sup = sup;
   endtask

   task automatic lookup_drain();
      @(negedge clk);
      present_pending();
      pend_valid = 1'b0;
      @(negedge clk);
      present_pending();
   endtask

   initial begin
      int          n;
      logic [31:0] va0;
      logic [31:0] va1;
      logic [31:0] word;
      void'($urandom(SEED));
      virt_addr_i = 32'h0;
      virt_addr_match_i = 32'h0;
      op_load_i = 1'b0;
      op_store_i = 1'b0;
      supervisor_mode_i = 1'b0;
      spr_bus_addr_i = 16'h0;
      spr_bus_we_i = 1'b0;
      spr_bus_stb_i = 1'b0;
      spr_bus_dat_i = 32'h0;
      chk_lookup = 1'b0;
      chk_read = 1'b0;
      exp_ack = 1'b0;
      pend_valid = 1'b0;
      n = 0;
      while (rst !== 1'b0) begin
         @(negedge clk);
         n++;
         if (n > RST_TIMEOUT) begin
            $display("Reset was never released");
            stop_failed();
         end
      end

      // Random words where way 1 VPNs keep bit 31 set so ways never collide
      for (int s = 0; s < 8; s++) begin
         for (int w = 0; w < NUM_WAYS; w++) begin
            word = $urandom();
            word[31] = w[0];
            tlb_write(w[0], 1'b0, s[5:0], word);
            tlb_write(w[0], 1'b1, s[5:0], $urandom());
            tlb_write(w[0], 1'b1, s[5:0], $urandom());
         end
      end
      for (int s = 0; s < 8; s++) begin
         for (int a = 0; a < 4; a++) begin
            tlb_read(a[1], a[0], s[5:0]);
         end
      end

      // Hits in both ways of one set, back to back
      for (int i = 0; i < 8; i++) begin
         va0 = $urandom();
         va0[31] = 1'b0;
         va1 = $urandom();
         va1[31] = 1'b1;
         va1[18:13] = va0[18:13];
         install(1'b0, va0, $urandom());
         install(1'b1, va1, $urandom());
         n = $urandom();
         lookup(va0, n[0], n[1], n[2]);
         lookup(va1, n[3], n[4], n[5]);
         lookup({va0[31:13], va1[12:0]}, n[6], n[7], n[8]);
         lookup_drain();
      end

      // Misses on a differing VPN, then on an invalidated entry
      lookup(va0 ^ 32'h0010_0000, 1'b1, 1'b0, 1'b1);
      lookup(va0 ^ 32'h0040_0000, 1'b0, 1'b1, 1'b0);
      lookup(va0 ^ 32'h0010_0000, 1'b0, 1'b0, 1'b0);
      lookup_drain();
      tlb_write(1'b0, 1'b0, va0[18:13], {va0[31:13], 13'h0000});
      lookup(va0, 1'b1, 1'b0, 1'b0);
      lookup(va0, 1'b0, 1'b1, 1'b1);
      lookup_drain();

      // Every permission set against both modes and both operations
      va0 = va1 & 32'h7fff_ffff;
      for (int p = 0; p < 16; p++) begin
         word = $urandom();
         word[9:6] = p[3:0];
         install(1'b0, va0, word);
         for (int m = 0; m < 4; m++) begin
            lookup(va0, ~m[0], m[0], m[1]);
         end
         lookup_drain();
      end

      // Group 1 outside the arrays, then another group
      spr_access(16'h0805, 1'b1, $urandom(), 1'b1, 32'h0);
      spr_access(16'h0805, 1'b0, 32'h0, 1'b1, 32'h0);
      for (int a = 0; a < 4; a++) begin
         tlb_read(a[1], a[0], 6'd5);
      end
      spr_access(16'h1A05, 1'b0, 32'h0, 1'b0, 32'h0);

      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: src.f
common/dmmu_spr_pkg.sv
common/dmmu_tlb_pkg.sv
hw/dmmu/dtlb_reg_array.sv
hw/dmmu/dtlb_lookup.sv
hw/dmmu/dmmu_spr_slave.sv
hw/dmmu/dmmu_top.sv
dv/dmmu_clk_gen.sv
dv/dmmu_tb.sv

// File: Makefile
# Verilator build and run for the data MMU testbench

TOP = dmmu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir

# Pass or fail is taken from the log, not from the exit status
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
